/* Bender.yml */
package:
  name: mini_mcu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mcu_pkg.sv
      - source/system_bus.sv
      - source/ram_bank.sv
      - source/dma_engine.sv
      - source/ao_peripheral.sv
      - source/mini_mcu.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_mini_mcu.sv

/* sim.f */
+incdir+source
source/mcu_pkg.sv
source/system_bus.sv
source/ram_bank.sv
source/dma_engine.sv
source/ao_peripheral.sv
source/mini_mcu.sv
tb/tb_mini_mcu.sv

/* source/ao_peripheral.sv */
// always-on register block
// exit value, GPIO output and DMA configuration/status
`timescale 1ns/100ps
`include "mcu_defines.svh"

module ao_peripheral
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_valid_i,
  input  logic  req_we_i,
  input  word_t req_addr_i,
  input  word_t req_wdata_i,
  output logic  rsp_valid_o,
  output word_t rsp_rdata_o,
  output word_t gpio_o,
  output word_t exit_value_o,
  output logic  exit_valid_o,
  output word_t dma_src_o,
  output word_t dma_dst_o,
  output word_t dma_len_o,
  output logic  dma_start_o,
  input  logic  dma_busy_i,
  input  logic  dma_done_i,
  output logic  dma_intr_o
);

  periph_reg_e reg_sel;
  logic        wr_en;
  word_t       rd_mux;

  word_t exit_value_q;
  logic  exit_valid_q;
  word_t gpio_q;
  word_t src_q;
  word_t dst_q;
  word_t len_q;
  logic  start_q;
  logic  done_q;
  logic  rsp_valid_q;
  word_t rdata_q;

  assign reg_sel = periph_reg_e'(req_addr_i[`MCU_PERIPH_OFF_W-1:0]);
  assign wr_en   = req_valid_i && req_we_i;

  always_comb begin
    case (reg_sel)
      REG_EXIT:     rd_mux = exit_value_q;
      REG_GPIO:     rd_mux = gpio_q;
      REG_DMA_SRC:  rd_mux = src_q;
      REG_DMA_DST:  rd_mux = dst_q;
      REG_DMA_LEN:  rd_mux = len_q;
      REG_DMA_CTRL: rd_mux = word_t'({done_q, dma_busy_i});
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      gpio_q       <= '0;
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      start_q      <= 1'b0;
      done_q       <= 1'b0;
      rsp_valid_q  <= 1'b0;
      rdata_q      <= '0;
    end else begin
      rsp_valid_q <= req_valid_i;
      start_q     <= 1'b0;
      if (req_valid_i) begin
        rdata_q <= rd_mux;
      end
      if (wr_en) begin
        case (reg_sel)
          REG_EXIT: begin
            exit_value_q <= req_wdata_i;
            exit_valid_q <= 1'b1;
          end
          REG_GPIO:    gpio_q <= req_wdata_i;
          REG_DMA_SRC: src_q  <= req_wdata_i;
          REG_DMA_DST: dst_q  <= req_wdata_i;
          REG_DMA_LEN: len_q  <= req_wdata_i;
          REG_DMA_CTRL: begin
            start_q <= req_wdata_i[0];
            if (req_wdata_i[0] || req_wdata_i[1]) begin
              done_q <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      // completion wins over a clear in the same cycle
      if (dma_done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_rdata_o  = rdata_q;
  assign gpio_o       = gpio_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;
  assign dma_src_o    = src_q;
  assign dma_dst_o    = dst_q;
  assign dma_len_o    = len_q;
  assign dma_start_o  = start_q;
  assign dma_intr_o   = done_q;

endmodule

/* source/dma_engine.sv */
// word-copy DMA engine
// reads a word, writes it back out, repeats for len words
`timescale 1ns/100ps

module dma_engine
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  word_t src_i,
  input  word_t dst_i,
  input  word_t len_i,
  input  logic  start_i,
  output logic  busy_o,
  output logic  done_o,
  // bus master port
  output logic  req_valid_o,
  input  logic  req_ready_i,
  output logic  req_we_o,
  output word_t req_addr_o,
  output word_t req_wdata_o,
  input  logic  rsp_valid_i,
  input  word_t rsp_rdata_i,
  input  logic  rsp_err_i
);

  dma_state_e state_q;
  word_t      src_q;
  word_t      dst_q;
  word_t      cnt_q;
  word_t      data_q;
  logic       last_word;

  assign last_word = (cnt_q == word_t'(1));

  assign busy_o      = (state_q != DMA_IDLE);
  assign req_valid_o = (state_q == DMA_READ) || (state_q == DMA_WRITE);
  assign req_we_o    = (state_q == DMA_WRITE);
  assign req_addr_o  = req_we_o ? dst_q : src_q;
  assign req_wdata_o = data_q;

  // done pulses on the final response, on an error, or for len zero
  always_comb begin
    case (state_q)
      DMA_IDLE:       done_o = start_i && (len_i == '0);
      DMA_READ_WAIT:  done_o = rsp_valid_i && rsp_err_i;
      DMA_WRITE_WAIT: done_o = rsp_valid_i && (rsp_err_i || last_word);
      default:        done_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= DMA_IDLE;
    end else begin
      case (state_q)
        DMA_IDLE: begin
          if (start_i && (len_i != '0)) begin
            state_q <= DMA_READ;
          end
        end
        DMA_READ: begin
          if (req_ready_i) begin
            state_q <= DMA_READ_WAIT;
          end
        end
        DMA_READ_WAIT: begin
          if (rsp_valid_i) begin
            state_q <= rsp_err_i ? DMA_IDLE : DMA_WRITE;
          end
        end
        DMA_WRITE: begin
          if (req_ready_i) begin
            state_q <= DMA_WRITE_WAIT;
          end
        end
        DMA_WRITE_WAIT: begin
          if (rsp_valid_i) begin
            state_q <= (rsp_err_i || last_word) ? DMA_IDLE : DMA_READ;
          end
        end
        default: state_q <= DMA_IDLE;
      endcase
    end
  end

  // copy pointers and the word in flight
  always_ff @(posedge clk_i) begin
    if ((state_q == DMA_IDLE) && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
      cnt_q <= len_i;
    end
    if ((state_q == DMA_READ_WAIT) && rsp_valid_i) begin
      data_q <= rsp_rdata_i;
    end
    if ((state_q == DMA_WRITE_WAIT) && rsp_valid_i) begin
      src_q <= src_q + word_t'(4);
      dst_q <= dst_q + word_t'(4);
      cnt_q <= cnt_q - word_t'(1);
    end
  end

endmodule

/* source/mcu_defines.svh */
// address map, widths and sizes for the mini MCU
`ifndef MCU_DEFINES_SVH
`define MCU_DEFINES_SVH

`define MCU_DATA_W 32
`define MCU_ADDR_W 32

// each RAM bank holds 256 words, 1 KiB
`define MCU_RAM_WORDS 256
`define MCU_RAM_IDX_W 8
`define MCU_RAM_BYTES 32'h0000_0400

`define MCU_RAM0_BASE 32'h0000_0000
`define MCU_RAM1_BASE 32'h0000_0400

// always-on peripheral window
`define MCU_PERIPH_BASE 32'h0001_0000
`define MCU_PERIPH_SIZE 32'h0000_0100
`define MCU_PERIPH_OFF_W 8

`endif

/* source/mcu_pkg.sv */
// shared types for the mini MCU bus, DMA and peripheral block
`include "mcu_defines.svh"

package mcu_pkg;

  typedef logic [`MCU_DATA_W-1:0] word_t;

  typedef enum logic [2:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_READ_WAIT,
    DMA_WRITE,
    DMA_WRITE_WAIT
  } dma_state_e;

  typedef enum logic [1:0] {
    SLV_RAM0,
    SLV_RAM1,
    SLV_PERIPH,
    SLV_NONE
  } bus_slave_e;

  // byte offsets inside the peripheral window
  typedef enum logic [`MCU_PERIPH_OFF_W-1:0] {
    REG_EXIT     = 8'h00,
    REG_GPIO     = 8'h04,
    REG_DMA_SRC  = 8'h08,
    REG_DMA_DST  = 8'h0C,
    REG_DMA_LEN  = 8'h10,
    REG_DMA_CTRL = 8'h14
  } periph_reg_e;

endpackage

/* source/mini_mcu.sv */
// mini MCU top level
// external master and DMA share the bus to two RAM banks and the AO block
`timescale 1ns/100ps

module mini_mcu
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  ext_req_valid_i,
  output logic  ext_req_ready_o,
  input  logic  ext_req_we_i,
  input  word_t ext_req_addr_i,
  input  word_t ext_req_wdata_i,
  output logic  ext_rsp_valid_o,
  output word_t ext_rsp_rdata_o,
  output logic  ext_rsp_err_o,
  output word_t gpio_o,
  output word_t exit_value_o,
  output logic  exit_valid_o,
  output logic  dma_intr_o
);

  // dma master port
  logic  dma_req_valid;
  logic  dma_req_ready;
  logic  dma_req_we;
  word_t dma_req_addr;
  word_t dma_req_wdata;
  logic  dma_rsp_valid;
  word_t dma_rsp_rdata;
  logic  dma_rsp_err;

  // slave ports
  logic  ram0_req_valid;
  logic  ram0_req_we;
  word_t ram0_req_addr;
  word_t ram0_req_wdata;
  logic  ram0_rsp_valid;
  word_t ram0_rsp_rdata;
  logic  ram1_req_valid;
  logic  ram1_req_we;
  word_t ram1_req_addr;
  word_t ram1_req_wdata;
  logic  ram1_rsp_valid;
  word_t ram1_rsp_rdata;
  logic  periph_req_valid;
  logic  periph_req_we;
  word_t periph_req_addr;
  word_t periph_req_wdata;
  logic  periph_rsp_valid;
  word_t periph_rsp_rdata;

  // dma configuration and status
  word_t dma_src;
  word_t dma_dst;
  word_t dma_len;
  logic  dma_start;
  logic  dma_busy;
  logic  dma_done;

  system_bus system_bus_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .ext_req_valid_i   (ext_req_valid_i),
    .ext_req_ready_o   (ext_req_ready_o),
    .ext_req_we_i      (ext_req_we_i),
    .ext_req_addr_i    (ext_req_addr_i),
    .ext_req_wdata_i   (ext_req_wdata_i),
    .ext_rsp_valid_o   (ext_rsp_valid_o),
    .ext_rsp_rdata_o   (ext_rsp_rdata_o),
    .ext_rsp_err_o     (ext_rsp_err_o),
    .dma_req_valid_i   (dma_req_valid),
    .dma_req_ready_o   (dma_req_ready),
    .dma_req_we_i      (dma_req_we),
    .dma_req_addr_i    (dma_req_addr),
    .dma_req_wdata_i   (dma_req_wdata),
    .dma_rsp_valid_o   (dma_rsp_valid),
    .dma_rsp_rdata_o   (dma_rsp_rdata),
    .dma_rsp_err_o     (dma_rsp_err),
    .ram0_req_valid_o  (ram0_req_valid),
    .ram0_req_we_o     (ram0_req_we),
    .ram0_req_addr_o   (ram0_req_addr),
    .ram0_req_wdata_o  (ram0_req_wdata),
    .ram0_rsp_valid_i  (ram0_rsp_valid),
    .ram0_rsp_rdata_i  (ram0_rsp_rdata),
    .ram1_req_valid_o  (ram1_req_valid),
    .ram1_req_we_o     (ram1_req_we),
    .ram1_req_addr_o   (ram1_req_addr),
    .ram1_req_wdata_o  (ram1_req_wdata),
    .ram1_rsp_valid_i  (ram1_rsp_valid),
    .ram1_rsp_rdata_i  (ram1_rsp_rdata),
    .periph_req_valid_o(periph_req_valid),
    .periph_req_we_o   (periph_req_we),
    .periph_req_addr_o (periph_req_addr),
    .periph_req_wdata_o(periph_req_wdata),
    .periph_rsp_valid_i(periph_rsp_valid),
    .periph_rsp_rdata_i(periph_rsp_rdata)
  );

  ram_bank ram_bank0_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(ram0_req_valid),
    .req_we_i   (ram0_req_we),
    .req_addr_i (ram0_req_addr),
    .req_wdata_i(ram0_req_wdata),
    .rsp_valid_o(ram0_rsp_valid),
    .rsp_rdata_o(ram0_rsp_rdata)
  );

  ram_bank ram_bank1_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(ram1_req_valid),
    .req_we_i   (ram1_req_we),
    .req_addr_i (ram1_req_addr),
    .req_wdata_i(ram1_req_wdata),
    .rsp_valid_o(ram1_rsp_valid),
    .rsp_rdata_o(ram1_rsp_rdata)
  );

  ao_peripheral ao_peripheral_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (periph_req_valid),
    .req_we_i    (periph_req_we),
    .req_addr_i  (periph_req_addr),
    .req_wdata_i (periph_req_wdata),
    .rsp_valid_o (periph_rsp_valid),
    .rsp_rdata_o (periph_rsp_rdata),
    .gpio_o      (gpio_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .dma_src_o   (dma_src),
    .dma_dst_o   (dma_dst),
    .dma_len_o   (dma_len),
    .dma_start_o (dma_start),
    .dma_busy_i  (dma_busy),
    .dma_done_i  (dma_done),
    .dma_intr_o  (dma_intr_o)
  );

  dma_engine dma_engine_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .src_i      (dma_src),
    .dst_i      (dma_dst),
    .len_i      (dma_len),
    .start_i    (dma_start),
    .busy_o     (dma_busy),
    .done_o     (dma_done),
    .req_valid_o(dma_req_valid),
    .req_ready_i(dma_req_ready),
    .req_we_o   (dma_req_we),
    .req_addr_o (dma_req_addr),
    .req_wdata_o(dma_req_wdata),
    .rsp_valid_i(dma_rsp_valid),
    .rsp_rdata_i(dma_rsp_rdata),
    .rsp_err_i  (dma_rsp_err)
  );

endmodule

/* source/ram_bank.sv */
// single-port word RAM bank
// registered read, responds one cycle after each request
`timescale 1ns/100ps
`include "mcu_defines.svh"

module ram_bank
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_valid_i,
  input  logic  req_we_i,
  input  word_t req_addr_i,
  input  word_t req_wdata_i,
  output logic  rsp_valid_o,
  output word_t rsp_rdata_o
);

  word_t                     mem [`MCU_RAM_WORDS];
  logic [`MCU_RAM_IDX_W-1:0] idx;
  logic                      rsp_valid_q;
  word_t                     rdata_q;

  // word index inside the bank
  assign idx = req_addr_i[`MCU_RAM_IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // read before write, a write returns the old word
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= mem[idx];
      if (req_we_i) begin
        mem[idx] <= req_wdata_i;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rdata_q;

endmodule

/* source/system_bus.sv */
// system bus for two masters and three slaves
// round-robin grant, one outstanding transaction, address decode
`timescale 1ns/100ps
`include "mcu_defines.svh"

module system_bus
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // external master
  input  logic  ext_req_valid_i,
  output logic  ext_req_ready_o,
  input  logic  ext_req_we_i,
  input  word_t ext_req_addr_i,
  input  word_t ext_req_wdata_i,
  output logic  ext_rsp_valid_o,
  output word_t ext_rsp_rdata_o,
  output logic  ext_rsp_err_o,
  // dma master
  input  logic  dma_req_valid_i,
  output logic  dma_req_ready_o,
  input  logic  dma_req_we_i,
  input  word_t dma_req_addr_i,
  input  word_t dma_req_wdata_i,
  output logic  dma_rsp_valid_o,
  output word_t dma_rsp_rdata_o,
  output logic  dma_rsp_err_o,
  // ram bank 0
  output logic  ram0_req_valid_o,
  output logic  ram0_req_we_o,
  output word_t ram0_req_addr_o,
  output word_t ram0_req_wdata_o,
  input  logic  ram0_rsp_valid_i,
  input  word_t ram0_rsp_rdata_i,
  // ram bank 1
  output logic  ram1_req_valid_o,
  output logic  ram1_req_we_o,
  output word_t ram1_req_addr_o,
  output word_t ram1_req_wdata_o,
  input  logic  ram1_rsp_valid_i,
  input  word_t ram1_rsp_rdata_i,
  // always-on peripherals
  output logic  periph_req_valid_o,
  output logic  periph_req_we_o,
  output word_t periph_req_addr_o,
  output word_t periph_req_wdata_o,
  input  logic  periph_rsp_valid_i,
  input  word_t periph_rsp_rdata_i
);

  logic       pend_q;
  logic       pend_dma_q;
  bus_slave_e pend_slv_q;
  logic       last_dma_q;

  logic                   gnt_dma;
  logic                   can_accept;
  logic                   xfer;
  logic                   req_we;
  logic [`MCU_ADDR_W-1:0] req_addr;
  word_t                  req_wdata;
  bus_slave_e             req_slv;

  logic  rsp_valid;
  word_t rsp_rdata;
  logic  rsp_err;

  // dma wins when alone or when ext had the last grant
  assign gnt_dma    = dma_req_valid_i && (!ext_req_valid_i || !last_dma_q);
  // a response this cycle retires the outstanding transfer
  assign can_accept = !pend_q || rsp_valid;
  assign xfer       = can_accept && (ext_req_valid_i || dma_req_valid_i);

  assign ext_req_ready_o = can_accept && ext_req_valid_i && !gnt_dma;
  assign dma_req_ready_o = can_accept && gnt_dma;

  assign req_we    = gnt_dma ? dma_req_we_i : ext_req_we_i;
  assign req_addr  = gnt_dma ? dma_req_addr_i : ext_req_addr_i;
  assign req_wdata = gnt_dma ? dma_req_wdata_i : ext_req_wdata_i;

  always_comb begin
    if ((req_addr - `MCU_RAM0_BASE) < `MCU_RAM_BYTES) begin
      req_slv = SLV_RAM0;
    end else if ((req_addr - `MCU_RAM1_BASE) < `MCU_RAM_BYTES) begin
      req_slv = SLV_RAM1;
    end else if ((req_addr - `MCU_PERIPH_BASE) < `MCU_PERIPH_SIZE) begin
      req_slv = SLV_PERIPH;
    end else begin
      req_slv = SLV_NONE;
    end
  end

  assign ram0_req_valid_o   = xfer && (req_slv == SLV_RAM0);
  assign ram0_req_we_o      = req_we;
  assign ram0_req_addr_o    = req_addr;
  assign ram0_req_wdata_o   = req_wdata;
  assign ram1_req_valid_o   = xfer && (req_slv == SLV_RAM1);
  assign ram1_req_we_o      = req_we;
  assign ram1_req_addr_o    = req_addr;
  assign ram1_req_wdata_o   = req_wdata;
  assign periph_req_valid_o = xfer && (req_slv == SLV_PERIPH);
  assign periph_req_we_o    = req_we;
  assign periph_req_addr_o  = req_addr;
  assign periph_req_wdata_o = req_wdata;

  always_comb begin
    rsp_valid = 1'b0;
    rsp_rdata = '0;
    rsp_err   = 1'b0;
    if (pend_q) begin
      case (pend_slv_q)
        SLV_RAM0: begin
          rsp_valid = ram0_rsp_valid_i;
          rsp_rdata = ram0_rsp_rdata_i;
        end
        SLV_RAM1: begin
          rsp_valid = ram1_rsp_valid_i;
          rsp_rdata = ram1_rsp_rdata_i;
        end
        SLV_PERIPH: begin
          rsp_valid = periph_rsp_valid_i;
          rsp_rdata = periph_rsp_rdata_i;
        end
        // unmapped, answered by the bus itself
        default: begin
          rsp_valid = 1'b1;
          rsp_err   = 1'b1;
        end
      endcase
    end
  end

  assign ext_rsp_valid_o = rsp_valid && !pend_dma_q;
  assign ext_rsp_rdata_o = rsp_rdata;
  assign ext_rsp_err_o   = rsp_err;
  assign dma_rsp_valid_o = rsp_valid && pend_dma_q;
  assign dma_rsp_rdata_o = rsp_rdata;
  assign dma_rsp_err_o   = rsp_err;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q     <= 1'b0;
      pend_dma_q <= 1'b0;
      pend_slv_q <= SLV_NONE;
      // ext master goes first after reset
      last_dma_q <= 1'b1;
    end else begin
      pend_q <= xfer || (pend_q && !rsp_valid);
      if (xfer) begin
        pend_dma_q <= gnt_dma;
        pend_slv_q <= req_slv;
        last_dma_q <= gnt_dma;
      end
    end
  end

endmodule

/* tb/tb_mini_mcu.sv */
// testbench for the mini MCU
// table-driven RAM and peripheral accesses, then DMA copies with bus contention
`timescale 1ns/100ps
`include "mcu_defines.svh"

module tb_mini_mcu
  import mcu_pkg::*;
();

  localparam int unsigned SEED      = 32'h4882b982;
  localparam int          DMA_WORDS = 8;
  localparam word_t       SRC0      = `MCU_RAM0_BASE + 32'h100;
  localparam word_t       DST0      = `MCU_RAM1_BASE + 32'h100;
  localparam word_t       SRC1      = `MCU_RAM0_BASE + 32'h200;
  localparam word_t       DST1      = `MCU_RAM1_BASE + 32'h300;

  typedef struct {
    bit    we;
    word_t addr;
    word_t wdata;
    word_t exp_rdata;
    bit    exp_err;
  } vector_t;

  logic  clk_i;
  logic  rst_n_i;
  logic  ext_req_valid_i;
  logic  ext_req_ready_o;
  logic  ext_req_we_i;
  word_t ext_req_addr_i;
  word_t ext_req_wdata_i;
  logic  ext_rsp_valid_o;
  word_t ext_rsp_rdata_o;
  logic  ext_rsp_err_o;
  word_t gpio_o;
  word_t exit_value_o;
  logic  exit_valid_o;
  logic  dma_intr_o;

  vector_t     vectors[$];
  word_t       model[word_t];
  word_t       ram_addrs[8];
  word_t       gpio_val;
  word_t       exit_val;
  word_t       rdata;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 2000;

  mini_mcu UUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ext_req_valid_i(ext_req_valid_i),
    .ext_req_ready_o(ext_req_ready_o),
    .ext_req_we_i   (ext_req_we_i),
    .ext_req_addr_i (ext_req_addr_i),
    .ext_req_wdata_i(ext_req_wdata_i),
    .ext_rsp_valid_o(ext_rsp_valid_o),
    .ext_rsp_rdata_o(ext_rsp_rdata_o),
    .ext_rsp_err_o  (ext_rsp_err_o),
    .gpio_o         (gpio_o),
    .exit_value_o   (exit_value_o),
    .exit_valid_o   (exit_valid_o),
    .dma_intr_o     (dma_intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // one external transfer and its response
  task automatic bus_access(input bit we, input word_t addr, input word_t wdata,
                            output word_t got_rdata, output bit got_err);
    @(posedge clk_i);
    ext_req_valid_i <= 1'b1;
    ext_req_we_i    <= we;
    ext_req_addr_i  <= addr;
    ext_req_wdata_i <= wdata;
    @(negedge clk_i);
    while (!ext_req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ext_req_valid_i <= 1'b0;
    @(negedge clk_i);
    while (!ext_rsp_valid_o) begin
      @(negedge clk_i);
    end
    got_rdata = ext_rsp_rdata_o;
    got_err   = ext_rsp_err_o;
  endtask

  task automatic write_word(input word_t addr, input word_t wdata);
    word_t got_rdata;
    bit    got_err;
    bus_access(1'b1, addr, wdata, got_rdata, got_err);
    check_flag("ext_rsp_err_o", got_err, 1'b0);
  endtask

  task automatic read_word(input word_t addr, output word_t got_rdata);
    bit got_err;
    bus_access(1'b0, addr, '0, got_rdata, got_err);
    check_flag("ext_rsp_err_o", got_err, 1'b0);
  endtask

  function automatic void add_vector(bit we, word_t addr, word_t wdata,
                                     word_t exp_rdata, bit exp_err);
    vector_t v;
    v.we        = we;
    v.addr      = addr;
    v.wdata     = wdata;
    v.exp_rdata = exp_rdata;
    v.exp_err   = exp_err;
    vectors.push_back(v);
  endfunction

  // bank edges and a few inner words in both banks
  function automatic void build_vectors();
    word_t data;
    ram_addrs = '{`MCU_RAM0_BASE, `MCU_RAM0_BASE + 32'h4, `MCU_RAM0_BASE + 32'h80,
                  `MCU_RAM0_BASE + 32'h3FC, `MCU_RAM1_BASE, `MCU_RAM1_BASE + 32'h4,
                  `MCU_RAM1_BASE + 32'h200, `MCU_RAM1_BASE + 32'h3FC};
    foreach (ram_addrs[i]) begin
      data = $urandom;
      model[ram_addrs[i]] = data;
      add_vector(1'b1, ram_addrs[i], data, '0, 1'b0);
    end
    foreach (ram_addrs[i]) begin
      add_vector(1'b0, ram_addrs[i], '0, model[ram_addrs[i]], 1'b0);
    end
    // unmapped holes answer with err and zero data
    add_vector(1'b0, 32'h0002_0000, '0, '0, 1'b1);
    add_vector(1'b1, 32'h0000_0800, $urandom, '0, 1'b1);
    add_vector(1'b0, `MCU_PERIPH_BASE + `MCU_PERIPH_SIZE, '0, '0, 1'b1);
    // unused peripheral offset reads zero
    add_vector(1'b0, `MCU_PERIPH_BASE + 32'h40, '0, '0, 1'b0);
    gpio_val = $urandom;
    add_vector(1'b1, `MCU_PERIPH_BASE + word_t'(REG_GPIO), gpio_val, '0, 1'b0);
    add_vector(1'b0, `MCU_PERIPH_BASE + word_t'(REG_GPIO), '0, gpio_val, 1'b0);
  endfunction

  task automatic apply_vectors();
    word_t got_rdata;
    bit    got_err;
    foreach (vectors[i]) begin
      bus_access(vectors[i].we, vectors[i].addr, vectors[i].wdata, got_rdata, got_err);
      check_flag("ext_rsp_err_o", got_err, vectors[i].exp_err);
      if (!vectors[i].we) begin
        check_word("ext_rsp_rdata_o", got_rdata, vectors[i].exp_rdata);
      end
    end
  endtask

  task automatic fill_source(input word_t src, input int n);
    word_t data;
    for (int i = 0; i < n; i++) begin
      data = $urandom;
      model[src + 4 * i] = data;
      write_word(src + 4 * i, data);
    end
  endtask

  task automatic start_dma(input word_t src, input word_t dst, input int n);
    write_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_SRC), src);
    write_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_DST), dst);
    write_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_LEN), word_t'(n));
    write_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_CTRL), 32'h1);
  endtask

  // poll the control register until done is set
  task automatic wait_dma_done();
    word_t ctrl;
    read_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_CTRL), ctrl);
    while (!ctrl[1]) begin
      read_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_CTRL), ctrl);
    end
    check_flag("dma busy", ctrl[0], 1'b0);
  endtask

  task automatic verify_copy(input word_t src, input word_t dst, input int n);
    word_t got;
    for (int i = 0; i < n; i++) begin
      read_word(dst + 4 * i, got);
      check_word("dma dst word", got, model[src + 4 * i]);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n_i         = 1'b0;
    ext_req_valid_i = 1'b0;
    ext_req_we_i    = 1'b0;
    ext_req_addr_i  = '0;
    ext_req_wdata_i = '0;
    build_vectors();
    cycle_limit = 20 * vectors.size() + 20 * 2 * DMA_WORDS + 300;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_flag("ext_req_ready_o", ext_req_ready_o, 1'b0);
    check_flag("ext_rsp_valid_o", ext_rsp_valid_o, 1'b0);
    check_flag("exit_valid_o", exit_valid_o, 1'b0);
    check_flag("dma_intr_o", dma_intr_o, 1'b0);
    check_word("gpio_o", gpio_o, '0);

    apply_vectors();
    check_word("gpio_o", gpio_o, gpio_val);

    // plain copy bank 0 to bank 1
    fill_source(SRC0, DMA_WORDS);
    start_dma(SRC0, DST0, DMA_WORDS);
    wait_dma_done();
    check_flag("dma_intr_o", dma_intr_o, 1'b1);
    verify_copy(SRC0, DST0, DMA_WORDS);

    // external reads compete with a running copy
    fill_source(SRC1, DMA_WORDS);
    start_dma(SRC1, DST1, DMA_WORDS);
    read_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_CTRL), rdata);
    check_flag("dma busy", rdata[0], 1'b1);
    foreach (ram_addrs[i]) begin
      read_word(ram_addrs[i], rdata);
      check_word("ext_rsp_rdata_o", rdata, model[ram_addrs[i]]);
    end
    wait_dma_done();
    check_flag("dma_intr_o", dma_intr_o, 1'b1);
    verify_copy(SRC1, DST1, DMA_WORDS);
    write_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_CTRL), 32'h2);
    check_flag("dma_intr_o", dma_intr_o, 1'b0);
    read_word(`MCU_PERIPH_BASE + word_t'(REG_DMA_CTRL), rdata);
    check_word("dma ctrl", rdata, '0);

    exit_val = $urandom;
    write_word(`MCU_PERIPH_BASE + word_t'(REG_EXIT), exit_val);
    check_flag("exit_valid_o", exit_valid_o, 1'b1);
    check_word("exit_value_o", exit_value_o, exit_val);

    $display("Simulation passed");
    $finish;
  end

endmodule
